//--- design/proc_isa_pkg.sv
package proc_isa_pkg;

    // field widths of the three instruction formats
    localparam int OPCODE_W = 5;
    localparam int REG_W    = 3;
    localparam int IMM5_W   = 5;   // I-format 1 immediate
    localparam int IMM8_W   = 8;   // I-format 2 immediate
    localparam int DISP_W   = 11;  // J-format displacement

    typedef logic [15:0] instr_t;      // one instruction word
    typedef logic [REG_W-1:0] reg_addr_t;  // r0 .. r7

    // formats, msb first
    //   R  : op[15:11] rs[10:8] rt[7:5] rd[4:2] funct[1:0]
    //   I1 : op[15:11] rs[10:8] rd[7:5] imm5[4:0]
    //   I2 : op[15:11] rs[10:8] imm8[7:0]
    //   J  : op[15:11] disp11[10:0]
    typedef enum logic [OPCODE_W-1:0] {
        op_halt   = 5'b00000,
        op_nop    = 5'b00001,
        op_j      = 5'b00100,  // pc + 2 + disp
        op_jr     = 5'b00101,  // rs + imm8
        op_jal    = 5'b00110,  // link into r7
        op_addi   = 5'b01000,
        op_subi   = 5'b01001,  // rs - imm
        op_xori   = 5'b01010,  // zero-extended imm
        op_andni  = 5'b01011,  // zero-extended imm
        op_beqz   = 5'b01100,
        op_bnez   = 5'b01101,
        op_st     = 5'b10000,  // M[rs + imm5] <- rd
        op_ld     = 5'b10001,  // rd <- M[rs + imm5]
        op_slbi   = 5'b10010,  // rs <- (rs << 8) | imm8
        op_lbi    = 5'b11000,  // rs <- sext(imm8)
        op_alu_rr = 5'b11011,  // ADD/SUB/XOR/ANDN, funct picks which
        op_seq    = 5'b11100,
        op_slt    = 5'b11101,  // signed
        op_sle    = 5'b11110   // signed
    } opcode_t;

    // funct field of op_alu_rr
    typedef enum logic [1:0] {
        fn_add  = 2'b00,
        fn_sub  = 2'b01,  // rs - rt
        fn_xor  = 2'b10,
        fn_andn = 2'b11   // rs & ~rt
    } funct_t;

endpackage

//--- design/proc_dp_pkg.sv
package proc_dp_pkg;

    typedef logic [15:0] word_t;  // data word and byte address

    // alu operation, b is imm16 or regv_2
    typedef enum logic [3:0] {
        alu_pass_a, alu_pass_b, alu_add, alu_sub,
        alu_xor, alu_andn, alu_slbi, alu_none
    } alu_op_t;

    // flag unit: zero tests for branches, signed compares for Sxx
    typedef enum logic [2:0] {
        fcu_zero, fcu_nonzero, fcu_eq, fcu_lt, fcu_le, fcu_none
    } fcu_op_t;

    // register write source
    typedef enum logic [1:0] {
        wb_alu, wb_mem, wb_link, wb_flag
    } wb_op_t;

    // next pc kind
    typedef enum logic [1:0] {
        flow_basic,  // pc + 2
        flow_cond,   // taken target if flag
        flow_jump,   // taken target always
        flow_reg     // alu result (JR)
    } flow_t;

endpackage

//--- design/fetch.sv
module fetch #(
    parameter int IMEM_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 halt,       // HALT decoded this cycle
    input  proc_dp_pkg::word_t   next_pc,
    input  logic                 load_en,
    input  proc_dp_pkg::word_t   load_addr,  // word index, not byte address
    input  proc_isa_pkg::instr_t load_data,
    output proc_isa_pkg::instr_t instr,
    output proc_dp_pkg::word_t   pc,
    output logic                 halted,
    output logic                 err
);

    localparam int IAW = $clog2(IMEM_WORDS);

    proc_isa_pkg::instr_t imem [IMEM_WORDS];

    // program loads only while the core sits in reset
    always_ff @(posedge clk) begin
        if (reset && load_en && (load_addr < proc_dp_pkg::word_t'(IMEM_WORDS))) begin
            imem[load_addr[IAW-1:0]] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= '0;
            halted <= 1'b0;
        end else begin
            if (halt)
                halted <= 1'b1;       // sticky until reset
            if (!(halt || halted))
                pc <= next_pc;        // hold on the HALT itself
        end
    end

    assign instr = imem[pc[IAW:1]];  // word indexed, async read

    // odd pc or past the end of imem
    assign err = pc[0] | (pc[15:1] >= 15'(IMEM_WORDS));

    a_pc_frozen: assert property (@(posedge clk) disable iff (reset)
        halted |=> $stable(pc));

endmodule

//--- design/regfile.sv
module regfile (
    input  logic                    clk,
    input  logic                    reset,
    input  proc_isa_pkg::reg_addr_t rd_addr_1,
    input  proc_isa_pkg::reg_addr_t rd_addr_2,
    input  proc_isa_pkg::reg_addr_t wr_addr,
    input  logic                    wr_en,
    input  proc_dp_pkg::word_t      wr_data,
    output proc_dp_pkg::word_t      rd_data_1,
    output proc_dp_pkg::word_t      rd_data_2
);

    proc_dp_pkg::word_t regs [8];

    // r0 is an ordinary register here, writes land like any other
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // async reads, a same-cycle write shows up next cycle
    assign rd_data_1 = regs[rd_addr_1];
    assign rd_data_2 = regs[rd_addr_2];

endmodule

//--- design/decode.sv
module decode (
    input  logic                    clk,
    input  logic                    reset,
    input  proc_dp_pkg::word_t      pc,
    input  proc_isa_pkg::instr_t    instr,
    input  proc_dp_pkg::word_t      alu_out,
    input  proc_dp_pkg::word_t      mem_out,
    input  logic                    flag,
    output logic                    halt,
    output proc_dp_pkg::alu_op_t    alu_op,
    output proc_dp_pkg::fcu_op_t    fcu_op,
    output proc_dp_pkg::word_t      regv_1,
    output proc_dp_pkg::word_t      regv_2,
    output proc_dp_pkg::word_t      imm16,
    output logic                    alu_b_imm,
    output proc_dp_pkg::flow_t      flow_ty,
    output proc_dp_pkg::word_t      next_pc_basic,
    output proc_dp_pkg::word_t      next_pc_taken,
    output logic                    mem_read_en,
    output logic                    mem_write_en,
    output logic                    reg_write_en,
    output proc_isa_pkg::reg_addr_t reg_write_addr,
    output proc_dp_pkg::word_t      reg_write_data,
    output logic                    err
);

    proc_isa_pkg::opcode_t opcode;
    proc_isa_pkg::funct_t  funct;
    proc_dp_pkg::wb_op_t   wb_op;
    proc_dp_pkg::word_t    imm5_s, imm5_z, imm8_s, imm8_z, disp_s;
    logic                  wr_en, st_en;

    assign opcode = proc_isa_pkg::opcode_t'(instr[15:11]);
    assign funct  = proc_isa_pkg::funct_t'(instr[1:0]);

    // immediate variants
    assign imm5_s = proc_dp_pkg::word_t'($signed(instr[proc_isa_pkg::IMM5_W-1:0]));
    assign imm5_z = proc_dp_pkg::word_t'(instr[proc_isa_pkg::IMM5_W-1:0]);
    assign imm8_s = proc_dp_pkg::word_t'($signed(instr[proc_isa_pkg::IMM8_W-1:0]));
    assign imm8_z = proc_dp_pkg::word_t'(instr[proc_isa_pkg::IMM8_W-1:0]);
    assign disp_s = proc_dp_pkg::word_t'($signed(instr[proc_isa_pkg::DISP_W-1:0]));

    always_comb begin
        halt           = 1'b0;
        alu_op         = proc_dp_pkg::alu_none;
        fcu_op         = proc_dp_pkg::fcu_none;
        alu_b_imm      = 1'b0;
        imm16          = imm5_s;
        flow_ty        = proc_dp_pkg::flow_basic;
        mem_read_en    = 1'b0;
        st_en          = 1'b0;
        wr_en          = 1'b0;
        wb_op          = proc_dp_pkg::wb_alu;
        reg_write_addr = instr[4:2];  // R-format rd
        err            = 1'b0;
        case (opcode)
            proc_isa_pkg::op_halt: halt = 1'b1;  // no writes
            proc_isa_pkg::op_nop: ;
            proc_isa_pkg::op_addi, proc_isa_pkg::op_subi,
            proc_isa_pkg::op_xori, proc_isa_pkg::op_andni: begin
                alu_b_imm      = 1'b1;
                wr_en          = 1'b1;
                reg_write_addr = instr[7:5];
                case (opcode)
                    proc_isa_pkg::op_addi: alu_op = proc_dp_pkg::alu_add;
                    proc_isa_pkg::op_subi: alu_op = proc_dp_pkg::alu_sub;
                    proc_isa_pkg::op_xori: alu_op = proc_dp_pkg::alu_xor;
                    default:               alu_op = proc_dp_pkg::alu_andn;
                endcase
                // logical immediates are zero-extended
                if (opcode == proc_isa_pkg::op_xori || opcode == proc_isa_pkg::op_andni)
                    imm16 = imm5_z;
            end
            proc_isa_pkg::op_alu_rr: begin
                wr_en = 1'b1;
                case (funct)
                    proc_isa_pkg::fn_add: alu_op = proc_dp_pkg::alu_add;
                    proc_isa_pkg::fn_sub: alu_op = proc_dp_pkg::alu_sub;
                    proc_isa_pkg::fn_xor: alu_op = proc_dp_pkg::alu_xor;
                    default:              alu_op = proc_dp_pkg::alu_andn;
                endcase
            end
            proc_isa_pkg::op_seq, proc_isa_pkg::op_slt, proc_isa_pkg::op_sle: begin
                wr_en = 1'b1;
                wb_op = proc_dp_pkg::wb_flag;
                case (opcode)
                    proc_isa_pkg::op_seq: fcu_op = proc_dp_pkg::fcu_eq;
                    proc_isa_pkg::op_slt: fcu_op = proc_dp_pkg::fcu_lt;
                    default:              fcu_op = proc_dp_pkg::fcu_le;
                endcase
            end
            proc_isa_pkg::op_lbi, proc_isa_pkg::op_slbi: begin
                alu_b_imm      = 1'b1;
                wr_en          = 1'b1;
                reg_write_addr = instr[10:8];  // rs is the target
                alu_op = (opcode == proc_isa_pkg::op_lbi) ? proc_dp_pkg::alu_pass_b
                                                          : proc_dp_pkg::alu_slbi;
                imm16  = (opcode == proc_isa_pkg::op_lbi) ? imm8_s : imm8_z;
            end
            proc_isa_pkg::op_beqz, proc_isa_pkg::op_bnez: begin
                flow_ty = proc_dp_pkg::flow_cond;
                fcu_op  = (opcode == proc_isa_pkg::op_beqz) ? proc_dp_pkg::fcu_zero
                                                            : proc_dp_pkg::fcu_nonzero;
            end
            proc_isa_pkg::op_j: flow_ty = proc_dp_pkg::flow_jump;
            proc_isa_pkg::op_jal: begin
                flow_ty        = proc_dp_pkg::flow_jump;
                wr_en          = 1'b1;
                wb_op          = proc_dp_pkg::wb_link;
                reg_write_addr = 3'd7;  // return address always in r7
            end
            proc_isa_pkg::op_jr: begin
                flow_ty   = proc_dp_pkg::flow_reg;
                alu_op    = proc_dp_pkg::alu_add;  // rs + imm8
                alu_b_imm = 1'b1;
                imm16     = imm8_s;
            end
            proc_isa_pkg::op_ld, proc_isa_pkg::op_st: begin
                alu_op    = proc_dp_pkg::alu_add;  // effective address
                alu_b_imm = 1'b1;
                if (opcode == proc_isa_pkg::op_ld) begin
                    mem_read_en    = 1'b1;
                    wr_en          = 1'b1;
                    wb_op          = proc_dp_pkg::wb_mem;
                    reg_write_addr = instr[7:5];
                end else begin
                    st_en = 1'b1;  // store data is rd, read on port 2
                end
            end
            default: err = 1'b1;  // opcode not in this subset
        endcase
    end

    // nothing commits while the program is being loaded
    assign reg_write_en = wr_en & ~reset;
    assign mem_write_en = st_en & ~reset;

    assign next_pc_basic = pc + 16'd2;
    assign next_pc_taken = next_pc_basic +
                           ((flow_ty == proc_dp_pkg::flow_jump) ? disp_s : imm8_s);

    always_comb begin
        case (wb_op)
            proc_dp_pkg::wb_alu:  reg_write_data = alu_out;
            proc_dp_pkg::wb_mem:  reg_write_data = mem_out;
            proc_dp_pkg::wb_link: reg_write_data = next_pc_basic;
            default:              reg_write_data = {15'b0, flag};  // Sxx result
        endcase
    end

    regfile u_regfile (
        .clk      (clk),
        .reset    (reset),
        .rd_addr_1(instr[10:8]),  // rs
        .rd_addr_2(instr[7:5]),   // rt, or rd for ST data
        .wr_addr  (reg_write_addr),
        .wr_en    (reg_write_en),
        .wr_data  (reg_write_data),
        .rd_data_1(regv_1),
        .rd_data_2(regv_2)
    );

    a_mem_excl: assert property (@(posedge clk) disable iff (reset)
        !(mem_read_en && mem_write_en));

endmodule

//--- design/execute.sv
module execute (
    input  proc_dp_pkg::alu_op_t alu_op,
    input  proc_dp_pkg::fcu_op_t fcu_op,
    input  proc_dp_pkg::word_t   regv_1,
    input  proc_dp_pkg::word_t   regv_2,
    input  proc_dp_pkg::word_t   imm16,
    input  logic                 alu_b_imm,
    input  proc_dp_pkg::flow_t   flow_ty,
    input  proc_dp_pkg::word_t   next_pc_basic,
    input  proc_dp_pkg::word_t   next_pc_taken,
    output proc_dp_pkg::word_t   alu_out,
    output logic                 flag,
    output proc_dp_pkg::word_t   next_pc,
    output logic                 err
);

    proc_dp_pkg::word_t alu_b;

    assign alu_b = alu_b_imm ? imm16 : regv_2;  // second operand

    always_comb begin
        case (alu_op)
            proc_dp_pkg::alu_pass_a: alu_out = regv_1;
            proc_dp_pkg::alu_pass_b: alu_out = alu_b;           // LBI
            proc_dp_pkg::alu_add:    alu_out = regv_1 + alu_b;
            proc_dp_pkg::alu_sub:    alu_out = regv_1 - alu_b;
            proc_dp_pkg::alu_xor:    alu_out = regv_1 ^ alu_b;
            proc_dp_pkg::alu_andn:   alu_out = regv_1 & ~alu_b;
            proc_dp_pkg::alu_slbi:   alu_out = {regv_1[7:0], alu_b[7:0]};
            default:                 alu_out = '0;              // alu idle
        endcase
    end

    // flag unit, signed compares
    always_comb begin
        case (fcu_op)
            proc_dp_pkg::fcu_zero:    flag = (regv_1 == '0);
            proc_dp_pkg::fcu_nonzero: flag = (regv_1 != '0);
            proc_dp_pkg::fcu_eq:      flag = (regv_1 == regv_2);
            proc_dp_pkg::fcu_lt:      flag = ($signed(regv_1) <  $signed(regv_2));
            proc_dp_pkg::fcu_le:      flag = ($signed(regv_1) <= $signed(regv_2));
            default:                  flag = 1'b0;
        endcase
    end

    always_comb begin
        case (flow_ty)
            proc_dp_pkg::flow_basic: next_pc = next_pc_basic;
            proc_dp_pkg::flow_cond:  next_pc = flag ? next_pc_taken : next_pc_basic;
            proc_dp_pkg::flow_jump:  next_pc = next_pc_taken;
            default:                 next_pc = alu_out;         // JR target
        endcase
    end

    // JR needs an alu result, a branch needs a flag op
    assign err = ((flow_ty == proc_dp_pkg::flow_reg) && (alu_op == proc_dp_pkg::alu_none)) |
                 ((flow_ty == proc_dp_pkg::flow_cond) && (fcu_op == proc_dp_pkg::fcu_none));

endmodule

//--- design/memory.sv
module memory #(
    parameter int DMEM_WORDS = 256
) (
    input  logic               clk,
    input  logic               reset,
    input  proc_dp_pkg::word_t addr,        // byte address from the alu
    input  proc_dp_pkg::word_t write_data,
    input  logic               read_en,
    input  logic               write_en,
    output proc_dp_pkg::word_t read_data,
    output logic               err
);

    localparam int DAW = $clog2(DMEM_WORDS);

    proc_dp_pkg::word_t dmem [DMEM_WORDS];
    logic               addr_ok;

    assign addr_ok = !addr[0] && (addr[15:1] < 15'(DMEM_WORDS));  // aligned and in range

    always_ff @(posedge clk) begin
        if (write_en && addr_ok)
            dmem[addr[DAW:1]] <= write_data;  // lands with the pc update
    end

    assign read_data = dmem[addr[DAW:1]];  // async, ST then LD sees new data next cycle

    assign err = (read_en | write_en) & ~addr_ok;

    a_no_wr_in_reset: assert property (@(posedge clk)
        reset |-> !write_en);

endmodule

//--- design/proc.sv
module proc #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    load_en,
    input  proc_dp_pkg::word_t      load_addr,
    input  proc_isa_pkg::instr_t    load_data,
    output logic                    err,
    output logic                    halted,
    output proc_dp_pkg::word_t      pc,
    output logic                    reg_write_en,
    output proc_isa_pkg::reg_addr_t reg_write_addr,
    output proc_dp_pkg::word_t      reg_write_data
);

    logic fetch_err, decode_err, exec_err, mem_err;

    proc_isa_pkg::instr_t instr;
    proc_dp_pkg::word_t   next_pc;           // loops back to fetch
    logic                 halt;
    proc_dp_pkg::alu_op_t alu_op;
    proc_dp_pkg::fcu_op_t fcu_op;
    proc_dp_pkg::flow_t   flow_ty;
    proc_dp_pkg::word_t   regv_1, regv_2, imm16;
    proc_dp_pkg::word_t   next_pc_basic, next_pc_taken;
    logic                 alu_b_imm;
    logic                 mem_read_en, mem_write_en;
    logic                 flag;              // Sxx result and branch condition
    proc_dp_pkg::word_t   alu_out, mem_out;

    assign err = fetch_err | decode_err | exec_err | mem_err;

    fetch #(.IMEM_WORDS(IMEM_WORDS)) u_fetch (
        .clk(clk), .reset(reset), .halt(halt), .next_pc(next_pc),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .instr(instr), .pc(pc), .halted(halted), .err(fetch_err)
    );

    decode u_decode (
        .clk(clk), .reset(reset), .pc(pc), .instr(instr),
        .alu_out(alu_out), .mem_out(mem_out), .flag(flag),
        .halt(halt), .alu_op(alu_op), .fcu_op(fcu_op),
        .regv_1(regv_1), .regv_2(regv_2), .imm16(imm16), .alu_b_imm(alu_b_imm),
        .flow_ty(flow_ty), .next_pc_basic(next_pc_basic), .next_pc_taken(next_pc_taken),
        .mem_read_en(mem_read_en), .mem_write_en(mem_write_en),
        .reg_write_en(reg_write_en), .reg_write_addr(reg_write_addr),
        .reg_write_data(reg_write_data), .err(decode_err)
    );

    execute u_execute (
        .alu_op(alu_op), .fcu_op(fcu_op),
        .regv_1(regv_1), .regv_2(regv_2), .imm16(imm16), .alu_b_imm(alu_b_imm),
        .flow_ty(flow_ty), .next_pc_basic(next_pc_basic), .next_pc_taken(next_pc_taken),
        .alu_out(alu_out), .flag(flag), .next_pc(next_pc), .err(exec_err)
    );

    // data memory is always addressed by the alu result
    memory #(.DMEM_WORDS(DMEM_WORDS)) u_memory (
        .clk(clk), .reset(reset), .addr(alu_out), .write_data(regv_2),
        .read_en(mem_read_en), .write_en(mem_write_en),
        .read_data(mem_out), .err(mem_err)
    );

endmodule

//--- testbench/proc_checker.sv
module proc_checker (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    halted,
    input  logic                    err,
    input  proc_dp_pkg::word_t      pc,
    input  logic                    reg_write_en,
    input  proc_isa_pkg::reg_addr_t reg_write_addr,
    input  proc_dp_pkg::word_t      reg_write_data,
    input  logic [8*24-1:0]         test_name,
    input  logic [7*16-1:0]         exp_regs,     // r1 in the low 16 bits
    output int                      pass_count,
    output int                      fail_count
);

    proc_dp_pkg::word_t shadow [8];  // register file as seen on the write port
    logic               reported;    // result line already printed
    logic               err_seen;
    proc_dp_pkg::word_t err_pc;      // first pc with err high
    proc_dp_pkg::word_t halt_pc;     // pc held while halted
    int                 passes = 0;
    int                 fails  = 0;

    assign pass_count = passes;
    assign fail_count = fails;

    // lowest mismatching register decides the line
    task automatic judge_test();
        int bad;
        bad = 0;
        for (int r = 7; r >= 1; r--) begin
            if (shadow[r] !== exp_regs[16*(r-1) +: 16])
                bad = r;
        end
        if (bad != 0) begin
            $display("Fail %0s r%0d expected 0x%04h actual 0x%04h", test_name, bad,
                     exp_regs[16*(bad-1) +: 16], shadow[bad]);
            fails++;
        end else if (err_seen) begin
            $display("test %0s reached HALT but err went high at pc 0x%04h", test_name, err_pc);
            fails++;
        end else begin
            $display("Pass %0s", test_name);
            passes++;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                shadow[i] <= '0;  // regfile clears on reset too
            end
            reported <= 1'b0;
            err_seen <= 1'b0;
        end else begin
            if (err === 1'b1 && !err_seen) begin
                err_seen <= 1'b1;
                err_pc   <= pc;
            end
            if (reg_write_en === 1'b1) begin
                shadow[reg_write_addr] <= reg_write_data;
                if (halted) begin  // HALT must freeze the register file
                    $display("register r%0d written after HALT in test %0s",
                             reg_write_addr, test_name);
                    fails++;
                end
            end
            if (halted && !reported) begin
                judge_test();
                reported <= 1'b1;
                halt_pc  <= pc;  // address of the HALT itself
            end else if (halted && pc !== halt_pc) begin
                $display("pc moved from 0x%04h to 0x%04h after HALT in test %0s",
                         halt_pc, pc, test_name);
                fails++;
            end
        end
    end

endmodule

//--- testbench/proc_tb.sv
module proc_tb;

    localparam int MAX_TESTS    = 16;
    localparam int MAX_WORDS    = 64;  // longest program
    localparam int RESET_CYCLES = 8;

    logic                    clk = 1'b0;
    logic                    reset, load_en, err, halted, reg_write_en;
    proc_dp_pkg::word_t      load_addr, pc, reg_write_data;
    proc_isa_pkg::instr_t    load_data;
    proc_isa_pkg::reg_addr_t reg_write_addr;
    logic [8*24-1:0]         test_name;
    logic [7*16-1:0]         exp_regs;
    int                      pass_count, fail_count;

    // whole cases file, read before the first test
    logic [8*24-1:0]      names [MAX_TESTS];
    logic [7*16-1:0]      expects [MAX_TESTS];
    proc_isa_pkg::instr_t progs [MAX_TESTS][MAX_WORDS];
    int                   nwords [MAX_TESTS];
    int                   ntests = 0;
    int                   total_words = 0;
    int                   watch_cycles = 0;  // 0 until the cases are in

    always #10 clk = ~clk;

    proc #(.IMEM_WORDS(256), .DMEM_WORDS(256)) dut (
        .clk(clk), .reset(reset), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .err(err), .halted(halted), .pc(pc),
        .reg_write_en(reg_write_en), .reg_write_addr(reg_write_addr),
        .reg_write_data(reg_write_data)
    );

    proc_checker u_checker (
        .clk(clk), .reset(reset), .halted(halted), .err(err), .pc(pc),
        .reg_write_en(reg_write_en), .reg_write_addr(reg_write_addr),
        .reg_write_data(reg_write_data), .test_name(test_name), .exp_regs(exp_regs),
        .pass_count(pass_count), .fail_count(fail_count)
    );

    task automatic read_cases();
        int               fd, code, n;
        logic [8*24-1:0]  name;
        logic [7*16-1:0]  want;
        logic [15:0]      w;
        logic [8*128-1:0] line;
        fd = $fopen("testbench/proc_cases.txt", "r");
        if (fd != 0) begin
            code = $fgets(line, fd);  // column description
            code = $fgets(line, fd);
            code = $fscanf(fd, "%s %d", name, n);
            while (code == 2 && n <= MAX_WORDS && ntests < MAX_TESTS) begin
                for (int i = 0; i < n; i++) begin
                    code = $fscanf(fd, "%h", w);
                    progs[ntests][i] = w;
                end
                for (int r = 0; r < 7; r++) begin
                    code = $fscanf(fd, "%h", w);
                    want[16*r +: 16] = w;   // r1 first in the file
                end
                names[ntests]   = name;
                expects[ntests] = want;
                nwords[ntests]  = n;
                total_words += n;
                ntests++;
                code = $fscanf(fd, "%s %d", name, n);
            end
            $fclose(fd);
        end
    endtask

    // reset, load the program during reset, run until halted
    task automatic run_test(input int t);
        int load_cycles;
        load_cycles = (nwords[t] > RESET_CYCLES) ? nwords[t] : RESET_CYCLES;
        for (int i = 0; i < load_cycles; i++) begin
            @(posedge clk);
            reset     <= 1'b1;
            test_name <= names[t];
            exp_regs  <= expects[t];
            load_en   <= (i < nwords[t]);  // reset stays up past the last word
            load_addr <= 16'(i);
            load_data <= progs[t][i];
        end
        @(posedge clk);
        load_en <= 1'b0;
        reset   <= 1'b0;
        @(posedge clk);
        while (!halted)
            @(posedge clk);
        repeat (2) @(posedge clk);  // checker reports, stray writes would show here
    endtask

    initial begin
        reset     = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        test_name = '0;
        exp_regs  = '0;
        read_cases();
        if (ntests == 0) begin
            $display("no test cases could be read from testbench/proc_cases.txt");
            $display("** FAIL **");
            $finish;
        end else begin
            watch_cycles = 50 + 4 * total_words;
            for (int t = 0; t < ntests; t++) begin
                run_test(t);
            end
            $display("tests passed %0d failed %0d", pass_count, fail_count);
            if (fail_count == 0 && pass_count == ntests) begin
                $display("** PASS **");
            end else begin
                $display("** FAIL **");
            end
            $finish;
        end
    end

    // watchdog, sized from the program lengths
    initial begin
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge clk);
        $display("timeout after %0d cycles, a program never reached HALT", watch_cycles);
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- proc.f
design/proc_isa_pkg.sv
design/proc_dp_pkg.sv
design/fetch.sv
design/regfile.sv
design/decode.sv
design/execute.sv
design/memory.sv
design/proc.sv
testbench/proc_checker.sv
testbench/proc_tb.sv

//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --assert -j 0
TOP        := proc_tb
FILELIST   := proc.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := ** PASS **

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/proc_cases.txt
# per test: name and program length in words, then the program words (hex, from pc 0),
# then the expected final r1 r2 r3 r4 r5 r6 r7 (hex)
arith_imm 8
c112 9134 c2fd 4265 499f 51bf 5acf 0000
1234 fffd 0002 1235 122b fff0 0000
arith_reg 8
c17f 91ff c201 d94c da31 d976 d95b 0000
7fff 0001 8000 8002 ffff 7ffe 0000
compares 8
c1fe c203 e94c ea30 e254 f138 e15c 0000
fffe 0003 0001 0000 0001 0001 0000
branches 11
c100 c205 6102 c311 6902 c422 6a02 c533 6202 c644 0000
0000 0005 0000 0022 0000 0044 0000
jumps 9
c101 2004 c255 0000 3004 c366 0000 c477 2f00
0001 0000 0066 0077 0000 0000 000a
load_store 10
c140 c25a 92a5 8140 c3ff 8164 8984 89a0 dcb8 0000
0040 5aa5 ffff ffff 5aa5 5aa4 0000
